/* include/skenc_settings.svh */
/*
 * Secret key encoder settings.
 * Dilithium modulus, vector sizes and memory geometry for the eta = 2 key packer.
 */
`ifndef SKENC_SETTINGS_SVH
`define SKENC_SETTINGS_SVH

// Prime modulus of the coefficient ring.
`define SKENC_Q 8380417

// Polynomial counts of the vectors s2 (K) and s1 (L).
`define SKENC_K 4
`define SKENC_L 4

// Coefficients per polynomial.
`define SKENC_N 256

// Width of every memory address in the subsystem.
`define SKENC_ADDR_W 15

// Read data shows up this many cycles after the request.
`define SKENC_RD_LAT 1

`endif

/* src/skenc_mem_pkg.sv */
/*
 * Memory side types for the secret key encoder.
 * Request opcodes, addresses, coefficient reads and packed key words.
 */
`default_nettype none

`include "skenc_settings.svh"

package skenc_mem_pkg;

    // Opcode carried on each memory port.
    typedef enum logic [1:0] {
        RW_IDLE  = 2'b00,
        RW_READ  = 2'b01,
        RW_WRITE = 2'b10
    } mem_op_e;

    typedef logic [`SKENC_ADDR_W-1:0] mem_addr_t;

    // One read returns four 24-bit residues, lane 0 in the low bits.
    typedef logic [3:0][23:0] coeff_quad_t;

    typedef logic [31:0] key_word_t;

endpackage

`default_nettype wire

/* src/skenc_eta_pkg.sv */
/*
 * Encoding side types for the secret key encoder.
 * Sequencer states and the 3-bit eta code.
 */
`default_nettype none

package skenc_eta_pkg;

    // Read sequencer states. DRAIN waits for the packer to finish.
    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'b00,
        SEQ_READ  = 2'b01,
        SEQ_DRAIN = 2'b10,
        SEQ_DONE  = 2'b11
    } seq_state_e;

    // Packed code for one coefficient, eta minus the value mod Q.
    typedef logic [2:0] eta_code_t;

endpackage

`default_nettype wire

/* src/sk_read_sequencer.sv */
/*
 * Secret key read sequencer.
 * Walks both coefficient read ports over the whole key and runs start, abort and done.
 */
`default_nettype none
`timescale 1ns/100ps

`include "skenc_settings.svh"

module sk_read_sequencer (
    input  wire logic                       clk,
    input  wire logic                       reset_n,
    input  wire logic                       zeroize,
    input  wire logic                       sk_enable,
    input  wire skenc_mem_pkg::mem_addr_t   src_base_addr,
    input  wire skenc_mem_pkg::mem_addr_t   dest_base_addr,
    output skenc_mem_pkg::mem_op_e          rd_a_op,
    output skenc_mem_pkg::mem_addr_t        rd_a_addr,
    output skenc_mem_pkg::mem_op_e          rd_b_op,
    output skenc_mem_pkg::mem_addr_t        rd_b_addr,
    output logic                            rd_issue,
    input  wire logic                       coeff_bad,
    input  wire logic                       last_word_written,
    output logic                            pass_start,
    output logic                            pass_abort,
    output skenc_mem_pkg::mem_addr_t        dest_addr_locked,
    output logic                            sk_done,
    output logic                            sk_error
);
    import skenc_mem_pkg::*;
    import skenc_eta_pkg::*;

    // Each read pair carries eight coefficients.
    localparam int PAIRS  = (`SKENC_K + `SKENC_L) * `SKENC_N / 8;
    localparam int PAIR_W = $clog2(PAIRS);
    localparam int RD_LAT = `SKENC_RD_LAT;

    seq_state_e         state;
    logic [PAIR_W-1:0]  pair_cnt;
    mem_addr_t          src_locked;
    logic [RD_LAT-1:0]  issue_pipe;
    logic               reading;

    // ======================================
    // Read requests
    // ======================================

    assign reading = (state == SEQ_READ);

    assign rd_a_op   = reading ? RW_READ : RW_IDLE;
    assign rd_b_op   = reading ? RW_READ : RW_IDLE;
    assign rd_a_addr = reading ? src_locked + mem_addr_t'({pair_cnt, 1'b0}) : '0;
    assign rd_b_addr = reading ? src_locked + mem_addr_t'({pair_cnt, 1'b1}) : '0;

    // The issue strobe follows the read data through the memory latency.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            issue_pipe <= '0;
        end else if (zeroize) begin
            issue_pipe <= '0;
        end else begin
            issue_pipe <= RD_LAT'({issue_pipe, reading});
        end
    end

    assign rd_issue = issue_pipe[RD_LAT-1];

    // ======================================
    // Pass control
    // ======================================

    assign pass_start = (state == SEQ_IDLE) && sk_enable;
    // A bad string must not reach the residue, so abort in its own cycle.
    assign pass_abort = coeff_bad && (state != SEQ_IDLE);
    assign sk_done    = (state == SEQ_DONE);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state            <= SEQ_IDLE;
            pair_cnt         <= '0;
            src_locked       <= '0;
            dest_addr_locked <= '0;
            sk_error         <= 1'b0;
        end else if (zeroize) begin
            state            <= SEQ_IDLE;
            pair_cnt         <= '0;
            src_locked       <= '0;
            dest_addr_locked <= '0;
            sk_error         <= 1'b0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (sk_enable) begin
                        state            <= SEQ_READ;
                        pair_cnt         <= '0;
                        src_locked       <= src_base_addr;
                        dest_addr_locked <= dest_base_addr;
                        sk_error         <= 1'b0;
                    end
                end
                SEQ_READ: begin
                    if (coeff_bad) begin
                        state    <= SEQ_IDLE;
                        sk_error <= 1'b1;
                    end else begin
                        pair_cnt <= pair_cnt + 1'b1;
                        if (pair_cnt == PAIR_W'(PAIRS - 1)) begin
                            state <= SEQ_DRAIN;
                        end
                    end
                end
                SEQ_DRAIN: begin
                    if (coeff_bad) begin
                        state    <= SEQ_IDLE;
                        sk_error <= 1'b1;
                    end else if (last_word_written) begin
                        state <= SEQ_DONE;
                    end
                end
                SEQ_DONE: begin
                    state <= SEQ_IDLE;
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/eta_coeff_encoder.sv */
/*
 * Eta = 2 coefficient encoder.
 * Turns eight residues per cycle into 3-bit codes and flags values outside the range.
 */
`default_nettype none
`timescale 1ns/100ps

`include "skenc_settings.svh"

module eta_coeff_encoder (
    input  wire logic                       clk,
    input  wire logic                       reset_n,
    input  wire logic                       zeroize,
    input  wire logic                       data_valid,
    input  wire skenc_mem_pkg::coeff_quad_t rd_a_data,
    input  wire skenc_mem_pkg::coeff_quad_t rd_b_data,
    output logic                            code_valid,
    output logic [23:0]                     code_string,
    output logic                            coeff_bad
);
    import skenc_eta_pkg::*;

    localparam logic [23:0] Q = 24'(`SKENC_Q);

    eta_code_t [7:0] lane_code;
    logic      [7:0] lane_bad;

    // Returns {illegal, code}. Only 0, 1, 2, Q-1 and Q-2 are legal.
    function automatic logic [3:0] map_coeff(input logic [23:0] coeff);
        logic [3:0] result;
        case (coeff)
            24'd0:      result = {1'b0, 3'd2};
            24'd1:      result = {1'b0, 3'd1};
            24'd2:      result = {1'b0, 3'd0};
            Q - 24'd1:  result = {1'b0, 3'd3};
            Q - 24'd2:  result = {1'b0, 3'd4};
            default:    result = {1'b1, 3'd0};
        endcase
        return result;
    endfunction

    // Port A fills lanes 0 to 3, port B lanes 4 to 7.
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            {lane_bad[i], lane_code[i]}         = map_coeff(rd_a_data[i]);
            {lane_bad[i + 4], lane_code[i + 4]} = map_coeff(rd_b_data[i]);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            code_valid  <= 1'b0;
            code_string <= '0;
            coeff_bad   <= 1'b0;
        end else if (zeroize) begin
            code_valid  <= 1'b0;
            code_string <= '0;
            coeff_bad   <= 1'b0;
        end else begin
            code_valid  <= data_valid;
            code_string <= lane_code;
            coeff_bad   <= data_valid && (|lane_bad);
        end
    end

endmodule

`default_nettype wire

/* src/sk_word_packer.sv */
/*
 * Key word packer.
 * Appends 24-bit code strings to a bit residue and writes full 32-bit words.
 */
`default_nettype none
`timescale 1ns/100ps

`include "skenc_settings.svh"

module sk_word_packer (
    input  wire logic                       clk,
    input  wire logic                       reset_n,
    input  wire logic                       zeroize,
    input  wire logic                       pass_start,
    input  wire logic                       pass_abort,
    input  wire skenc_mem_pkg::mem_addr_t   dest_addr_locked,
    input  wire logic                       code_valid,
    input  wire logic [23:0]                code_string,
    output skenc_mem_pkg::mem_op_e          wr_op,
    output skenc_mem_pkg::mem_addr_t        wr_addr,
    output skenc_mem_pkg::key_word_t        wr_data,
    output logic                            last_word_written
);
    import skenc_mem_pkg::*;

    localparam int WORDS  = (`SKENC_K + `SKENC_L) * `SKENC_N * 3 / 32;
    localparam int WORD_W = $clog2(WORDS);
    // At most 31 bits stay behind a write, plus one 24-bit string.
    localparam int RES_W  = 55;

    logic              active;
    logic [RES_W-1:0]  residue;
    logic [5:0]        res_cnt;
    logic [WORD_W-1:0] word_cnt;
    logic              emit;
    logic [RES_W-1:0]  kept;
    logic [5:0]        kept_cnt;
    logic [RES_W-1:0]  residue_next;
    logic [5:0]        res_cnt_next;

    // ======================================
    // Write port
    // ======================================

    // A word goes out in any cycle that holds 32 bits, so the input never waits.
    assign emit = active && (res_cnt >= 6'd32);

    assign wr_op             = emit ? RW_WRITE : RW_IDLE;
    assign wr_addr           = emit ? dest_addr_locked + mem_addr_t'(word_cnt) : '0;
    assign wr_data           = emit ? residue[31:0] : '0;
    assign last_word_written = emit && (word_cnt == WORD_W'(WORDS - 1));

    // ======================================
    // Residue update
    // ======================================

    always_comb begin
        kept         = emit ? (residue >> 32) : residue;
        kept_cnt     = emit ? (res_cnt - 6'd32) : res_cnt;
        residue_next = kept;
        res_cnt_next = kept_cnt;
        if (code_valid) begin
            residue_next = kept | (RES_W'(code_string) << kept_cnt);
            res_cnt_next = kept_cnt + 6'd24;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            active   <= 1'b0;
            residue  <= '0;
            res_cnt  <= '0;
            word_cnt <= '0;
        end else if (zeroize) begin
            active   <= 1'b0;
            residue  <= '0;
            res_cnt  <= '0;
            word_cnt <= '0;
        end else if (pass_start) begin
            active   <= 1'b1;
            residue  <= '0;
            res_cnt  <= '0;
            word_cnt <= '0;
        end else if (pass_abort || last_word_written) begin
            // Anything still in flight is dropped once the pass ends.
            active <= 1'b0;
        end else if (active) begin
            residue  <= residue_next;
            res_cnt  <= res_cnt_next;
            word_cnt <= word_cnt + WORD_W'(emit);
        end
    end

endmodule

`default_nettype wire

/* src/skencode_top.sv */
/*
 * Secret key encoder top level.
 * Read sequencer, eta encoder and word packer between the memory ports.
 */
`default_nettype none
`timescale 1ns/100ps

module skencode_top (
    input  wire logic                       clk,
    input  wire logic                       reset_n,
    input  wire logic                       zeroize,
    input  wire logic                       sk_enable,
    input  wire skenc_mem_pkg::mem_addr_t   src_base_addr,
    input  wire skenc_mem_pkg::mem_addr_t   dest_base_addr,
    output skenc_mem_pkg::mem_op_e          rd_a_op,
    output skenc_mem_pkg::mem_addr_t        rd_a_addr,
    input  wire skenc_mem_pkg::coeff_quad_t rd_a_data,
    output skenc_mem_pkg::mem_op_e          rd_b_op,
    output skenc_mem_pkg::mem_addr_t        rd_b_addr,
    input  wire skenc_mem_pkg::coeff_quad_t rd_b_data,
    output skenc_mem_pkg::mem_op_e          wr_op,
    output skenc_mem_pkg::mem_addr_t        wr_addr,
    output skenc_mem_pkg::key_word_t        wr_data,
    output logic                            sk_done,
    output logic                            sk_error
);
    import skenc_mem_pkg::*;

    logic        rd_issue;
    logic        code_valid;
    logic [23:0] code_string;
    logic        coeff_bad;
    logic        pass_start;
    logic        pass_abort;
    logic        last_word_written;
    mem_addr_t   dest_addr_locked;

    sk_read_sequencer u_seq (
        .clk               (clk),
        .reset_n           (reset_n),
        .zeroize           (zeroize),
        .sk_enable         (sk_enable),
        .src_base_addr     (src_base_addr),
        .dest_base_addr    (dest_base_addr),
        .rd_a_op           (rd_a_op),
        .rd_a_addr         (rd_a_addr),
        .rd_b_op           (rd_b_op),
        .rd_b_addr         (rd_b_addr),
        .rd_issue          (rd_issue),
        .coeff_bad         (coeff_bad),
        .last_word_written (last_word_written),
        .pass_start        (pass_start),
        .pass_abort        (pass_abort),
        .dest_addr_locked  (dest_addr_locked),
        .sk_done           (sk_done),
        .sk_error          (sk_error)
    );

    eta_coeff_encoder u_enc (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize     (zeroize),
        .data_valid  (rd_issue),
        .rd_a_data   (rd_a_data),
        .rd_b_data   (rd_b_data),
        .code_valid  (code_valid),
        .code_string (code_string),
        .coeff_bad   (coeff_bad)
    );

    sk_word_packer u_pack (
        .clk               (clk),
        .reset_n           (reset_n),
        .zeroize           (zeroize),
        .pass_start        (pass_start),
        .pass_abort        (pass_abort),
        .dest_addr_locked  (dest_addr_locked),
        .code_valid        (code_valid),
        .code_string       (code_string),
        .wr_op             (wr_op),
        .wr_addr           (wr_addr),
        .wr_data           (wr_data),
        .last_word_written (last_word_written)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
/*
 * Testbench clock and reset source.
 * 10 ns clock, reset held low for the first 4 cycles.
 */
`default_nettype none
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        reset_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
    end

endmodule

`default_nettype wire

/* testbench/skencode_sva.sv */
/*
 * Protocol assertions for the secret key encoder top level.
 * Bound into every skencode_top instance.
 */
`default_nettype none
`timescale 1ns/100ps

module skencode_sva (
    input wire logic                        clk,
    input wire logic                        reset_n,
    input wire logic                        zeroize,
    input wire skenc_mem_pkg::mem_op_e      rd_a_op,
    input wire skenc_mem_pkg::mem_op_e      rd_b_op,
    input wire skenc_mem_pkg::mem_op_e      wr_op,
    input wire skenc_eta_pkg::seq_state_e   seq_state,
    input wire logic                        sk_done,
    input wire logic                        sk_error
);
    import skenc_mem_pkg::*;
    import skenc_eta_pkg::*;

    // A write belongs to a running pass, so the sequencer is never idle then.
    write_in_pass: assert property (@(posedge clk) disable iff (!reset_n || zeroize)
        (wr_op == RW_WRITE) |-> (seq_state != SEQ_IDLE))
        else $error("write outside of a pass");

    done_single_cycle: assert property (@(posedge clk) disable iff (!reset_n || zeroize)
        sk_done |=> !sk_done)
        else $error("done held for more than one cycle");

    reads_paired: assert property (@(posedge clk) disable iff (!reset_n || zeroize)
        rd_a_op == rd_b_op)
        else $error("read ports issued apart");

    no_write_after_error: assert property (@(posedge clk) disable iff (!reset_n || zeroize)
        sk_error |-> (wr_op != RW_WRITE))
        else $error("write while the error flag is set");

endmodule

bind skencode_top skencode_sva u_sva (
    .clk       (clk),
    .reset_n   (reset_n),
    .zeroize   (zeroize),
    .rd_a_op   (rd_a_op),
    .rd_b_op   (rd_b_op),
    .wr_op     (wr_op),
    .seq_state (u_seq.state),
    .sk_done   (sk_done),
    .sk_error  (sk_error)
);

`default_nettype wire

/* testbench/tb_skencode.sv */
/*
 * Testbench for the secret key encoder.
 * Models both memories, checks every write against a reference packer.
 */
`default_nettype none
`timescale 1ns/100ps

`include "skenc_settings.svh"

module tb_skencode;
    import skenc_mem_pkg::*;
    import skenc_eta_pkg::*;

    localparam int          WORDS       = (`SKENC_K + `SKENC_L) * `SKENC_N * 3 / 32;
    localparam int          ENTRIES     = (`SKENC_K + `SKENC_L) * `SKENC_N / 4;
    localparam int          PASS_CYCLES = 256 + 200;
    localparam int          RD_LAT      = `SKENC_RD_LAT;
    localparam logic [23:0] Q           = 24'(`SKENC_Q);

    logic        clk;
    logic        reset_n;
    logic        zeroize;
    logic        sk_enable;
    mem_addr_t   src_base_addr;
    mem_addr_t   dest_base_addr;
    mem_op_e     rd_a_op;
    mem_op_e     rd_b_op;
    mem_op_e     wr_op;
    mem_addr_t   rd_a_addr;
    mem_addr_t   rd_b_addr;
    mem_addr_t   wr_addr;
    coeff_quad_t rd_a_data;
    coeff_quad_t rd_b_data;
    key_word_t   wr_data;
    logic        sk_done;
    logic        sk_error;

    coeff_quad_t coef_mem [0:(1 << `SKENC_ADDR_W) - 1];
    key_word_t   key_mem  [0:(1 << `SKENC_ADDR_W) - 1];
    mem_addr_t   lat_a    [0:RD_LAT - 1];
    mem_addr_t   lat_b    [0:RD_LAT - 1];
    logic        pend_a   [0:RD_LAT - 1];
    logic        pend_b   [0:RD_LAT - 1];

    int          seed;
    int          errors;
    int          tests;
    int          failed;
    int          test_err_base;
    mem_addr_t   cur_src;
    mem_addr_t   cur_dest;
    int          wcount;
    int          done_count;
    logic        prev_last_write;

    tb_clock_gen u_clk (
        .clk     (clk),
        .reset_n (reset_n)
    );

    skencode_top u_dut (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .sk_enable      (sk_enable),
        .src_base_addr  (src_base_addr),
        .dest_base_addr (dest_base_addr),
        .rd_a_op        (rd_a_op),
        .rd_a_addr      (rd_a_addr),
        .rd_a_data      (rd_a_data),
        .rd_b_op        (rd_b_op),
        .rd_b_addr      (rd_b_addr),
        .rd_b_data      (rd_b_data),
        .wr_op          (wr_op),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .sk_done        (sk_done),
        .sk_error       (sk_error)
    );

    // ========================================
    // Reference model
    // ========================================

    // Code is eta minus the value, taken modulo Q.
    function automatic eta_code_t eta_code(input logic [23:0] v);
        if (v <= 24'd2) begin
            return eta_code_t'(24'd2 - v);
        end
        return eta_code_t'(24'd2 + Q - v);
    endfunction

    // Returns word idx of the packed bit stream, where coefficient c sits at bits 3c up to 3c+2.
    function automatic key_word_t ref_word(input int idx, input mem_addr_t src);
        key_word_t w;
        int        b;
        int        c;
        int        lane;
        mem_addr_t a;
        eta_code_t code;
        w = '0;
        for (int k = 0; k < 32; k++) begin
            b    = idx * 32 + k;
            c    = b / 3;
            lane = c % 8;
            a    = src + mem_addr_t'(2 * (c / 8) + lane / 4);
            code = eta_code(coef_mem[a][lane % 4]);
            w[k] = code[b % 3];
        end
        return w;
    endfunction

    function automatic logic [23:0] legal_value(input int sel);
        case (sel)
            0:       return 24'd0;
            1:       return 24'd1;
            2:       return 24'd2;
            3:       return Q - 24'd1;
            default: return Q - 24'd2;
        endcase
    endfunction

    // ========================================
    // Compare tasks
    // ========================================

    task automatic check_word(input key_word_t got, input key_word_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("** Error @ %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input mem_addr_t got, input mem_addr_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("** Error @ %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("** Error @ %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // ========================================
    // Memory models
    // ========================================

    // Read requests travel down a pipeline as deep as the read latency.
    // The data is driven on the falling edge before the DUT samples it.
    always @(posedge clk) begin
        pend_a[0] <= (rd_a_op == RW_READ);
        pend_b[0] <= (rd_b_op == RW_READ);
        lat_a[0]  <= rd_a_addr;
        lat_b[0]  <= rd_b_addr;
        for (int i = 1; i < RD_LAT; i++) begin
            pend_a[i] <= pend_a[i - 1];
            pend_b[i] <= pend_b[i - 1];
            lat_a[i]  <= lat_a[i - 1];
            lat_b[i]  <= lat_b[i - 1];
        end
    end

    always @(negedge clk) begin
        if (pend_a[RD_LAT - 1]) begin
            rd_a_data <= coef_mem[lat_a[RD_LAT - 1]];
        end
        if (pend_b[RD_LAT - 1]) begin
            rd_b_data <= coef_mem[lat_b[RD_LAT - 1]];
        end
    end

    // Write checker. Outputs come from registers, so the falling edge sees them settled.
    always @(negedge clk) begin
        if (reset_n) begin
            if (sk_done) begin
                done_count++;
                check_flag(prev_last_write, 1'b1, "done one cycle after last write");
            end
            prev_last_write = 1'b0;
            if (wr_op == RW_WRITE) begin
                key_mem[wr_addr] = wr_data;
                check_flag(sk_error, 1'b0, "error flag during write");
                check_addr(wr_addr, cur_dest + mem_addr_t'(wcount), "write address");
                check_word(wr_data, ref_word(wcount, cur_src), "write data");
                prev_last_write = (wcount == WORDS - 1);
                wcount++;
            end
        end
    end

    // ========================================
    // Stimulus
    // ========================================

    task automatic fill_random(input mem_addr_t src);
        coeff_quad_t q;
        for (int i = 0; i < ENTRIES; i++) begin
            for (int l = 0; l < 4; l++) begin
                q[l] = legal_value(($random(seed) & 32'h7fffffff) % 5);
            end
            coef_mem[src + mem_addr_t'(i)] = q;
        end
    endtask

    task automatic fill_const(input mem_addr_t src, input logic [23:0] v);
        for (int i = 0; i < ENTRIES; i++) begin
            coef_mem[src + mem_addr_t'(i)] = {4{v}};
        end
    endtask

    task automatic start_pass(input mem_addr_t src, input mem_addr_t dest);
        @(negedge clk);
        cur_src        = src;
        cur_dest       = dest;
        wcount         = 0;
        done_count     = 0;
        src_base_addr  = src;
        dest_base_addr = dest;
        sk_enable      = 1'b1;
        @(negedge clk);
        sk_enable = 1'b0;
    endtask

    task automatic pulse_zeroize();
        @(negedge clk);
        zeroize = 1'b1;
        @(negedge clk);
        zeroize = 1'b0;
    endtask

    task automatic wait_end(output logic done, output logic err);
        int n;
        n    = 0;
        done = 1'b0;
        err  = 1'b0;
        while (!done && !err && n < PASS_CYCLES) begin
            @(negedge clk);
            done = sk_done;
            err  = sk_error;
            n++;
        end
        if (!done && !err) begin
            errors++;
            $display("Pass did not end within %0d cycles.", PASS_CYCLES);
        end
    endtask

    task automatic good_pass(input mem_addr_t src, input mem_addr_t dest);
        logic done;
        logic err;
        start_pass(src, dest);
        wait_end(done, err);
        #1;
        check_flag(done, 1'b1, "done pulse");
        check_flag(err, 1'b0, "error flag");
        check_flag(wcount == WORDS, 1'b1, "192 words written");
        check_flag(done_count == 1, 1'b1, "single done pulse");
    endtask

    task automatic begin_test();
        test_err_base = errors;
        tests++;
    endtask

    task automatic end_test(input string name);
        if (errors == test_err_base) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed++;
            $display("test %0d %s: FAILED with %0d errors", tests, name, errors - test_err_base);
        end
    endtask

    initial begin
        logic done;
        logic err;
        zeroize         = 1'b0;
        sk_enable       = 1'b0;
        src_base_addr   = '0;
        dest_base_addr  = '0;
        rd_a_data       = '0;
        rd_b_data       = '0;
        seed            = 32'h0bdff6cd;
        errors          = 0;
        tests           = 0;
        failed          = 0;
        wcount          = 0;
        done_count      = 0;
        prev_last_write = 1'b0;
        cur_src         = '0;
        cur_dest        = '0;
        @(posedge reset_n);

        begin_test();
        fill_random(15'h0000);
        good_pass(15'h0000, 15'h4000);
        end_test("random key");

        begin_test();
        fill_const(15'h1200, Q - 24'd1);
        good_pass(15'h1200, 15'h0345);
        check_word(key_mem[15'h0345], 32'hdb6db6db, "all Q-1 first word");
        fill_const(15'h1200, Q - 24'd2);
        good_pass(15'h1200, 15'h0345);
        check_word(key_mem[15'h0345], 32'h24924924, "all Q-2 first word");
        end_test("edge values");

        // Back to back after the first pass of this test.
        begin_test();
        fill_random(15'h2000);
        good_pass(15'h2000, 15'h5000);
        fill_random(15'h3000);
        good_pass(15'h3000, 15'h5100);
        end_test("back to back");

        begin_test();
        fill_random(15'h0800);
        coef_mem[15'h0800 + 15'd81][2] = 24'd5;
        start_pass(15'h0800, 15'h6000);
        wait_end(done, err);
        check_flag(err, 1'b1, "error flag on illegal value");
        check_flag(done, 1'b0, "done on illegal value");
        repeat (20) @(negedge clk);
        #1;
        check_flag(done_count == 0, 1'b1, "no done after error");
        check_flag(wcount < WORDS, 1'b1, "pass cut short");
        check_flag(sk_error, 1'b1, "error flag sticky");
        end_test("illegal coefficient");

        // The error flag of the previous test is still set when this one starts.
        begin_test();
        check_flag(sk_error, 1'b1, "error flag before zeroize");
        pulse_zeroize();
        check_flag(sk_error, 1'b0, "error after zeroize");
        fill_random(15'h0400);
        start_pass(15'h0400, 15'h7000);
        repeat (60) @(negedge clk);
        zeroize = 1'b1;
        @(negedge clk);
        zeroize = 1'b0;
        check_flag(rd_a_op == RW_IDLE && rd_b_op == RW_IDLE, 1'b1, "reads idle after zeroize");
        check_flag(wr_op == RW_IDLE, 1'b1, "write idle after zeroize");
        check_flag(sk_done, 1'b0, "done after zeroize");
        good_pass(15'h0400, 15'h7100);
        end_test("zeroize");

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Six full passes of budget, plus the reset.
    initial begin
        #(6 * PASS_CYCLES * 10 + 100);
        $display("Watchdog expired before the tests finished.");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+include
src/skenc_mem_pkg.sv
src/skenc_eta_pkg.sv
src/sk_read_sequencer.sv
src/eta_coeff_encoder.sv
src/sk_word_packer.sv
src/skencode_top.sv
testbench/tb_clock_gen.sv
testbench/skencode_sva.sv
testbench/tb_skencode.sv

/* Makefile */
SRCS := include/skenc_settings.svh \
	src/skenc_mem_pkg.sv src/skenc_eta_pkg.sv \
	src/sk_read_sequencer.sv src/eta_coeff_encoder.sv \
	src/sk_word_packer.sv src/skencode_top.sv \
	testbench/tb_clock_gen.sv testbench/skencode_sva.sv testbench/tb_skencode.sv

.PHONY: all run clean

all: run

obj_dir/Vtb_skencode: src.f $(SRCS)
	verilator --binary --timing --assert -f src.f --top-module tb_skencode -o Vtb_skencode

run: obj_dir/Vtb_skencode
	./obj_dir/Vtb_skencode > sim.log 2>&1; cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
